/* design/cpuPkg.sv */
// Shared types, encodings and constants of the core; imported by every RTL module.
package cpuPkg;

  localparam int dataWidth = 16;
  localparam int numRegs = 4;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [1:0] regIdx_t;
  typedef logic [3:0] flags_t; // N, Z, C, V from the top bit down.

  localparam word_t resetPc = 16'h0000;

  // branch conditions, taken from the rs field of B.
  localparam logic [1:0] condAlways = 2'd0;
  localparam logic [1:0] condEq = 2'd1;
  localparam logic [1:0] condNe = 2'd2;
  localparam logic [1:0] condCs = 2'd3;

  // instruction class in bits 15 to 12. Codes 14 and 15 run as no-operations.
  typedef enum logic [3:0] {
    opAdd  = 4'd0,
    opAdc  = 4'd1,
    opSub  = 4'd2,
    opAnd  = 4'd3,
    opOr   = 4'd4,
    opXor  = 4'd5,
    opMovi = 4'd6,
    opAddi = 4'd7,
    opLdr  = 4'd8,
    opStr  = 4'd9,
    opB    = 4'd10,
    opBl   = 4'd11,
    opRet  = 4'd12,
    opHalt = 4'd13
  } opClass_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluAdc,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB
  } aluOp_t;

  typedef enum logic [2:0] {
    stReset,
    stFetchAddr,
    stFetchData,
    stDecode,
    stExecute,
    stMemAddr,
    stMemData,
    stHalted
  } ctrlState_t;

endpackage

/* design/alu.sv */
// Combinational ALU of the datapath; gives the result and the N, Z, C, V flags.
`timescale 1ns/1ps

module alu (
  input  cpuPkg::word_t  a,
  input  cpuPkg::word_t  b,
  input  cpuPkg::aluOp_t aluOp,
  input  logic           carryIn,
  output cpuPkg::word_t  result,
  output cpuPkg::flags_t flagsOut
);

  import cpuPkg::*;

  logic [dataWidth:0] sum;
  logic carry;
  logic overflow;

  always_comb begin
    sum = '0;
    carry = 1'b0;
    overflow = 1'b0;
    case (aluOp)
      aluAdd, aluAdc: begin
        sum = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, (aluOp == aluAdc) & carryIn};
        result = sum[dataWidth-1:0];
        carry = sum[dataWidth];
        overflow = (a[dataWidth-1] == b[dataWidth-1]) && (result[dataWidth-1] != a[dataWidth-1]);
      end
      aluSub: begin
        // carry out of a + ~b + 1 is set when there is no borrow.
        sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
        result = sum[dataWidth-1:0];
        carry = sum[dataWidth];
        overflow = (a[dataWidth-1] != b[dataWidth-1]) && (result[dataWidth-1] != a[dataWidth-1]);
      end
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      default: result = b; // pass b for MOVI.
    endcase
  end

  assign flagsOut = {result[dataWidth-1], result == '0, carry, overflow};

endmodule

/* design/regFile.sv */
// General register file of the datapath: four words, one write port, two read ports.
`timescale 1ns/1ps

module regFile (
  input  logic             Clock,
  input  logic             arstN,
  input  logic             we,
  input  cpuPkg::regIdx_t  wrIdx,
  input  cpuPkg::regIdx_t  rdIdxA,
  input  cpuPkg::regIdx_t  rdIdxB,
  input  cpuPkg::word_t    wrData,
  output cpuPkg::word_t    rdDataA,
  output cpuPkg::word_t    rdDataB
);

  import cpuPkg::*;

  word_t regs [numRegs];

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wrIdx] <= wrData;
    end
  end

  // reads are combinational so operands are ready within the execute cycle.
  assign rdDataA = regs[rdIdxA];
  assign rdDataB = regs[rdIdxB];

endmodule

/* design/datapath.sv */
// Datapath of the core: PC, IR, LR, flags, bus register and operand muxes around ALU and registers.
`timescale 1ns/1ps

module datapath (
  input  logic            Clock,
  input  logic            arstN,
  input  cpuPkg::word_t   dataIn,
  input  cpuPkg::aluOp_t  aluOp,
  input  logic            op1Sel,
  input  logic            op2Sel,
  input  logic            aluEn,
  input  logic            lrWe,
  input  logic            pcWe,
  input  logic [1:0]      pcSel,
  input  logic            irWe,
  input  logic            wdSel,
  input  logic            immSel,
  input  logic            regWe,
  input  logic            memEn,
  input  cpuPkg::regIdx_t rs1Sel,
  input  cpuPkg::regIdx_t rwSel,
  input  logic            nWait,
  output cpuPkg::word_t   dataOut,
  output logic [7:0]      opcode,
  output cpuPkg::flags_t  flags
);

  import cpuPkg::*;

  word_t pc;
  word_t ir;
  word_t lr;
  word_t adReg;
  flags_t flagReg;
  word_t pcPlus;
  word_t pcNext;
  word_t imm;
  word_t opA;
  word_t opB;
  word_t regA;
  word_t regB;
  word_t aluResult;
  flags_t aluFlags;
  word_t wrData;
  logic hold;

  // a read data phase holds every register until nWait goes high.
  assign hold = !nWait && (irWe || (regWe && wdSel));

  assign imm = immSel ? {{8{ir[7]}}, ir[7:0]} : {8'h00, ir[7:0]};
  assign opA = op1Sel ? pc : regA;
  assign opB = op2Sel ? imm : regB;
  assign wrData = wdSel ? dataIn : aluResult;
  assign pcPlus = pc + 1'b1;

  always_comb begin
    case (pcSel)
      2'd1:    pcNext = aluResult; // branch target.
      2'd2:    pcNext = lr;
      default: pcNext = pcPlus;
    endcase
  end

  regFile regFile (
    .Clock   (Clock),
    .arstN   (arstN),
    .we      (regWe && !hold),
    .wrIdx   (rwSel),
    .rdIdxA  (rs1Sel),
    .rdIdxB  (ir[9:8]),
    .wrData  (wrData),
    .rdDataA (regA),
    .rdDataB (regB)
  );

  alu alu (
    .a        (opA),
    .b        (opB),
    .aluOp    (aluOp),
    .carryIn  (flagReg[1]),
    .result   (aluResult),
    .flagsOut (aluFlags)
  );

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      pc <= resetPc;
      ir <= '0;
      flagReg <= '0;
    end else if (!hold) begin
      if (pcWe) pc <= pcNext;
      if (irWe) ir <= dataIn;
      if (aluEn) flagReg <= aluFlags;
    end
  end

  // LR takes the already incremented PC, which is the return address.
  always_ff @(posedge Clock) begin
    if (lrWe) lr <= pc;
  end

  // outside memory cycles adReg follows the ALU, so it holds the LDR/STR address
  // after EXECUTE; in memory cycles it takes the store data.
  always_ff @(posedge Clock) begin
    adReg <= memEn ? regA : aluResult;
  end

  assign dataOut = memEn ? adReg : pc;
  assign opcode = ir[15:8];
  assign flags = flagReg;

endmodule

/* design/control.sv */
// Control FSM of the core; decodes the opcode, steers the datapath and drives the bus strobes.
`timescale 1ns/1ps

module control (
  input  logic              Clock,
  input  logic              arstN,
  input  logic [7:0]        opcode,
  input  cpuPkg::flags_t    flags,
  input  logic              nWait,
  output cpuPkg::aluOp_t    aluOp,
  output logic              op1Sel,
  output logic              op2Sel,
  output logic              aluEn,
  output logic              lrWe,
  output logic              pcWe,
  output logic [1:0]        pcSel,
  output logic              irWe,
  output logic              wdSel,
  output logic              immSel,
  output logic              regWe,
  output logic              memEn,
  output cpuPkg::regIdx_t   rs1Sel,
  output cpuPkg::regIdx_t   rwSel,
  output logic              ALE,
  output logic              nME,
  output logic              nOE,
  output logic              RnW,
  output logic              ENB
);

  import cpuPkg::*;

  ctrlState_t state;
  ctrlState_t nextState;
  opClass_t opClass;
  regIdx_t rd;
  regIdx_t rs;
  logic taken;
  logic isStore;

  assign opClass = opClass_t'(opcode[7:4]);
  assign rd = opcode[3:2];
  assign rs = opcode[1:0];
  assign isStore = (opClass == opStr);

  always_comb begin
    case (rs)
      condEq:  taken = flags[2];
      condNe:  taken = !flags[2];
      condCs:  taken = flags[1];
      default: taken = 1'b1; // condAlways.
    endcase
  end

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) state <= stReset;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      stReset:     nextState = stFetchAddr;
      stFetchAddr: nextState = stFetchData;
      stFetchData: if (nWait) nextState = stDecode;
      stDecode:    nextState = stExecute;
      stExecute: begin
        if (opClass == opLdr || opClass == opStr) nextState = stMemAddr;
        else if (opClass == opHalt) nextState = stHalted;
        else nextState = stFetchAddr;
      end
      stMemAddr:   nextState = stMemData;
      stMemData:   if (nWait) nextState = stFetchAddr;
      default:     nextState = stHalted;
    endcase
  end

  // datapath steering, Moore style on the state and the decoded opcode.
  always_comb begin
    aluOp = aluAdd;
    op1Sel = 1'b0;
    op2Sel = 1'b0;
    aluEn = 1'b0;
    lrWe = 1'b0;
    pcWe = 1'b0;
    pcSel = 2'd0;
    irWe = 1'b0;
    wdSel = 1'b0;
    immSel = 1'b0;
    regWe = 1'b0;
    memEn = 1'b0;
    rs1Sel = rd;
    rwSel = rd;
    case (state)
      stFetchData: begin
        irWe = 1'b1;
        pcWe = 1'b1; // PC moves on as the instruction is captured.
      end
      stExecute: begin
        case (opClass)
          opAdd, opAdc, opSub, opAnd, opOr, opXor: begin
            aluOp = aluOp_t'(opcode[6:4]);
            aluEn = 1'b1;
            regWe = 1'b1;
          end
          opMovi: begin
            aluOp = aluPassB;
            op2Sel = 1'b1;
            regWe = 1'b1;
          end
          opAddi: begin
            op2Sel = 1'b1;
            aluEn = 1'b1;
            regWe = 1'b1;
          end
          opLdr, opStr: begin
            rs1Sel = rs; // base register plus offset.
            op2Sel = 1'b1;
          end
          opB, opBl: begin
            op1Sel = 1'b1;
            op2Sel = 1'b1;
            immSel = 1'b1;
            pcSel = 2'd1;
            pcWe = (opClass == opBl) || taken;
            lrWe = (opClass == opBl);
          end
          opRet: begin
            pcSel = 2'd2;
            pcWe = 1'b1;
          end
          default: ;
        endcase
      end
      stMemAddr: memEn = 1'b1;
      stMemData: begin
        memEn = 1'b1;
        wdSel = 1'b1;
        regWe = !isStore;
      end
      default: ;
    endcase
  end

  assign ALE = (state == stFetchAddr) || (state == stMemAddr);
  assign nME = !((state == stFetchData) || (state == stMemData));
  assign RnW = !((state == stMemData) && isStore);
  assign ENB = (state == stMemData) && isStore;
  assign nOE = !((state == stFetchData) || ((state == stMemData) && !isStore));

  aOeRnW: assert property (@(posedge Clock) disable iff (!arstN) nOE || RnW);
  aAlePulse: assert property (@(posedge Clock) disable iff (!arstN) ALE |=> !ALE);
  aAleNme: assert property (@(posedge Clock) disable iff (!arstN) !(ALE && !nME));

endmodule

/* design/cpuCore.sv */
// Top level of the processor core; joins control and datapath to the memory bus.
`timescale 1ns/1ps

module cpuCore (
  output cpuPkg::word_t dataOut,
  output logic          nOE,
  output logic          nME,
  output logic          ALE,
  output logic          ENB,
  output logic          RnW,
  input  cpuPkg::word_t dataIn,
  input  logic          nWait,
  input  logic          Clock,
  input  logic          arstN
);

  import cpuPkg::*;

  aluOp_t aluOp;
  logic op1Sel;
  logic op2Sel;
  logic aluEn;
  logic lrWe;
  logic pcWe;
  logic [1:0] pcSel;
  logic irWe;
  logic wdSel;
  logic immSel;
  logic regWe;
  logic memEn;
  regIdx_t rs1Sel;
  regIdx_t rwSel;
  flags_t flags;
  logic [7:0] opcode;

  control control (
    .Clock  (Clock),
    .arstN  (arstN),
    .opcode (opcode),
    .flags  (flags),
    .nWait  (nWait),
    .aluOp  (aluOp),
    .op1Sel (op1Sel),
    .op2Sel (op2Sel),
    .aluEn  (aluEn),
    .lrWe   (lrWe),
    .pcWe   (pcWe),
    .pcSel  (pcSel),
    .irWe   (irWe),
    .wdSel  (wdSel),
    .immSel (immSel),
    .regWe  (regWe),
    .memEn  (memEn),
    .rs1Sel (rs1Sel),
    .rwSel  (rwSel),
    .ALE    (ALE),
    .nME    (nME),
    .nOE    (nOE),
    .RnW    (RnW), // high for reads.
    .ENB    (ENB)
  );

  datapath datapath (
    .Clock   (Clock),
    .arstN   (arstN),
    .dataIn  (dataIn),
    .aluOp   (aluOp),
    .op1Sel  (op1Sel),
    .op2Sel  (op2Sel),
    .aluEn   (aluEn),
    .lrWe    (lrWe),
    .pcWe    (pcWe),
    .pcSel   (pcSel),
    .irWe    (irWe),
    .wdSel   (wdSel),
    .immSel  (immSel),
    .regWe   (regWe),
    .memEn   (memEn),
    .rs1Sel  (rs1Sel),
    .rwSel   (rwSel),
    .nWait   (nWait),
    .dataOut (dataOut),
    .opcode  (opcode),
    .flags   (flags)
  );

endmodule

/* verification/cpuModel.svh */
// Instruction-set model of the core, included in the testbench module to predict every bus cycle.
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

word_t mRegs [numRegs];
flags_t mFlags;
word_t mPc;
word_t mLr;
word_t mMem [256];
bit modelHalted;
word_t expAddr [$]; // predicted bus cycles, oldest first.
bit expWrite [$];
word_t expData [$];

function automatic void resetModel();
  foreach (mRegs[i]) mRegs[i] = '0;
  mFlags = '0;
  mPc = resetPc;
  mLr = '0;
  modelHalted = 1'b0;
endfunction

function automatic void pushBus(word_t addr, bit write, word_t data);
  expAddr.push_back(addr);
  expWrite.push_back(write);
  expData.push_back(data);
endfunction

// add and subtract with flags taken from the unsigned and signed results.
function automatic word_t arith(word_t a, word_t b, bit cin, bit isSub);
  int sr;
  int unsigned ur;
  bit c;
  word_t r;
  if (isSub) begin
    sr = int'($signed(a)) - int'($signed(b));
    c = (a >= b); // no borrow.
    r = a - b;
  end else begin
    sr = int'($signed(a)) + int'($signed(b)) + int'(cin);
    ur = 32'(a) + 32'(b) + 32'(cin);
    c = (ur > 32'h0000_ffff);
    r = ur[15:0];
  end
  mFlags = {r[15], r == 16'h0000, c, (sr > 32767) || (sr < -32768)};
  return r;
endfunction

function automatic word_t logicFlags(word_t r);
  mFlags = {r[15], r == 16'h0000, 2'b00};
  return r;
endfunction

// runs the instruction at mPc and queues its fetch and any data cycle.
function automatic void stepModel();
  word_t instr;
  word_t addr;
  word_t target;
  regIdx_t rd;
  regIdx_t rs;
  bit take;
  instr = mMem[mPc[7:0]];
  rd = instr[11:10];
  rs = instr[9:8];
  addr = mRegs[rs] + {8'h00, instr[7:0]};
  pushBus(mPc, 1'b0, 16'h0000);
  mPc = mPc + 16'd1;
  target = mPc + {{8{instr[7]}}, instr[7:0]};
  take = (rs == condAlways) || (rs == condEq && mFlags[2]) || (rs == condNe && !mFlags[2]) ||
         (rs == condCs && mFlags[1]);
  case (instr[15:12])
    opAdd:  mRegs[rd] = arith(mRegs[rd], mRegs[rs], 1'b0, 1'b0);
    opAdc:  mRegs[rd] = arith(mRegs[rd], mRegs[rs], mFlags[1], 1'b0);
    opSub:  mRegs[rd] = arith(mRegs[rd], mRegs[rs], 1'b0, 1'b1);
    opAnd:  mRegs[rd] = logicFlags(mRegs[rd] & mRegs[rs]);
    opOr:   mRegs[rd] = logicFlags(mRegs[rd] | mRegs[rs]);
    opXor:  mRegs[rd] = logicFlags(mRegs[rd] ^ mRegs[rs]);
    opMovi: mRegs[rd] = {8'h00, instr[7:0]};
    opAddi: mRegs[rd] = arith(mRegs[rd], {8'h00, instr[7:0]}, 1'b0, 1'b0);
    opLdr: begin
      pushBus(addr, 1'b0, 16'h0000);
      mRegs[rd] = mMem[addr[7:0]];
    end
    opStr: begin
      pushBus(addr, 1'b1, mRegs[rd]);
      mMem[addr[7:0]] = mRegs[rd];
    end
    opB:    if (take) mPc = target;
    opBl: begin
      mLr = mPc;
      mPc = target;
    end
    opRet:  mPc = mLr;
    opHalt: modelHalted = 1'b1;
    default: ; // codes 14 and 15 do nothing.
  endcase
endfunction

`endif

/* verification/cpuCoreTb.sv */
// Self-checking testbench of cpuCore: random program, wait-state memory and bus checker.
`timescale 1ns/1ps

module cpuCoreTb;

  import cpuPkg::*;

  localparam int progLen = 200;
  localparam int maxWait = 3;
  localparam int maxCycles = progLen * (6 + 2 * maxWait) + 100; // every instruction at its slowest.
  localparam int blPos = 90;
  localparam int subLen = 4;
  localparam int retPos = blPos + subLen + 2;
  localparam int storeStart = progLen - 5;
  localparam int phIdle = 0;
  localparam int phAddr = 1;
  localparam int phData = 2;

  logic Clock;
  logic arstN;
  logic nWait;
  word_t dataIn;
  word_t dataOut;
  logic nOE;
  logic nME;
  logic ALE;
  logic ENB;
  logic RnW;
  word_t strobes;
  word_t mem [256];
  int errorCount;
  int checkCount;
  int cycleCount;
  int phase;
  int waitLeft;
  bit endDriven;
  bit curWrite;
  word_t curData;
  word_t busAddr;
  word_t heldOut;
  word_t heldStrobes;

  `include "cpuModel.svh"

  cpuCore UUT (
    .dataOut (dataOut),
    .nOE     (nOE),
    .nME     (nME),
    .ALE     (ALE),
    .ENB     (ENB),
    .RnW     (RnW),
    .dataIn  (dataIn),
    .nWait   (nWait),
    .Clock   (Clock),
    .arstN   (arstN)
  );

  assign strobes = {11'd0, ALE, nME, nOE, RnW, ENB};

  initial begin
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  task automatic compareValue(string name, word_t expected, word_t actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("Mismatch %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  function automatic word_t encode(logic [3:0] op, regIdx_t rd, regIdx_t rs, logic [7:0] imm8);
    return {op, rd, rs, imm8};
  endfunction

  // r3 is only ever a base, so data accesses stay in 0xd0 to 0xf7.
  function automatic word_t randomDataInstr();
    int k;
    regIdx_t rd;
    logic [7:0] imm8;
    k = $urandom % 10;
    rd = 2'($urandom % 3);
    imm8 = 8'($urandom);
    if (k < 6) return encode(4'(k), rd, 2'($urandom % 4), imm8);
    else if (k == 6) return encode(opMovi, rd, 2'd0, imm8);
    else if (k == 7) return encode(opAddi, rd, 2'd0, imm8);
    else if (k == 8) return encode(opLdr, rd, 2'd3, 8'($urandom % 40));
    return encode(opStr, 2'($urandom % 4), 2'd3, 8'($urandom % 40));
  endfunction

  task automatic buildProgram();
    int k;
    int off;
    foreach (mem[a]) mem[a] = {8'(a) ^ 8'h5a, 8'(a * 3)};
    mem[0] = encode(opMovi, 2'd3, 2'd0, 8'hd0);
    for (int p = 1; p < storeStart; p++) begin
      k = $urandom % 10;
      off = $urandom % 7;
      if (p == blPos) mem[p] = encode(opBl, 2'd0, condAlways, 8'd1);
      else if (p == blPos + 1) mem[p] = encode(opB, 2'd0, condAlways, 8'(subLen + 1));
      else if (p == retPos) mem[p] = encode(opRet, 2'd0, 2'd0, 8'd0);
      else if ((p > blPos + 1 && p < retPos) || k < 7) mem[p] = randomDataInstr();
      else if (k < 9) begin
        // forward only, never past BL, into the subroutine or past the final stores.
        if (p + 1 + off > storeStart || (p + 1 + off > blPos && p + 1 + off <= retPos)) begin
          off = 0;
        end
        mem[p] = encode(opB, 2'd0, 2'($urandom % 4), 8'(off));
      end else mem[p] = encode(4'(14 + $urandom % 2), 2'd0, 2'd0, 8'($urandom));
    end
    for (int r = 0; r < numRegs; r++) begin
      mem[storeStart + r] = encode(opStr, 2'(r), 2'd3, 8'(8'h28 + r));
    end
    mem[progLen - 1] = encode(opHalt, 2'd0, 2'd0, 8'd0);
    foreach (mem[a]) mMem[a] = mem[a];
  endtask

  task automatic startCycle();
    busAddr = dataOut;
    if (expAddr.size() == 0 && !modelHalted) stepModel();
    if (expAddr.size() == 0) begin
      errorCount++;
      $display("A bus cycle to address %h started after HALT at %0t", dataOut, $time);
      curWrite = 1'b0;
    end else begin
      compareValue("bus address", expAddr.pop_front(), dataOut);
      curWrite = expWrite.pop_front();
      curData = expData.pop_front();
    end
    phase = phAddr;
  endtask

  task automatic driveMemory();
    endDriven = 1'b0;
    nWait = 1'b1;
    if (phase == phData) begin
      if (waitLeft > 0) begin
        waitLeft--;
        nWait = 1'b0;
        dataIn = word_t'($urandom); // junk that must not be captured.
      end else begin
        endDriven = 1'b1;
        if (RnW) dataIn = mem[busAddr[7:0]];
        else mem[busAddr[7:0]] = dataOut;
      end
    end
  endtask

  // outputs settle after the rising edge, so the bus is watched and driven on the falling edge.
  always @(negedge Clock) begin
    if (!arstN) begin
      compareValue("strobes in reset", 16'h000e, strobes);
    end else begin
      if (phase == phData && endDriven) phase = phIdle;
      if (phase == phData) begin
        compareValue("strobes in wait", heldStrobes, strobes);
        compareValue("dataOut in wait", heldOut, dataOut);
      end else if (phase == phAddr) begin
        compareValue("data phase strobes", curWrite ? 16'h0005 : 16'h0002, strobes);
        if (curWrite) compareValue("store data", curData, dataOut);
        heldStrobes = strobes;
        heldOut = dataOut;
        waitLeft = $urandom % (maxWait + 1);
        phase = phData;
      end else if (ALE) begin
        compareValue("address phase strobes", 16'h001e, strobes);
        startCycle();
      end else begin
        compareValue("idle strobes", 16'h000e, strobes);
      end
      driveMemory();
    end
  end

  always @(posedge Clock) begin
    cycleCount++;
    if (cycleCount > maxCycles) begin
      $display("Timeout: the core did not halt within %0d cycles", maxCycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int unsigned seed;
    seed = 32'h0960_0cb9;
    void'($urandom(seed));
    arstN = 1'b0;
    nWait = 1'b1;
    dataIn = '0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    phase = phIdle;
    waitLeft = 0;
    endDriven = 1'b0;
    buildProgram();
    resetModel();
    repeat (8) @(negedge Clock);
    arstN <= 1'b1;
    @(negedge Clock);
    compareValue("ALE after reset", 16'h0001, {15'd0, ALE});
    compareValue("first address", resetPc, dataOut);
    while (!(modelHalted && phase == phIdle && expAddr.size() == 0)) @(posedge Clock);
    repeat (20) @(posedge Clock); // any ALE here is flagged by the bus checker.
    foreach (mem[a]) compareValue($sformatf("mem[%02h]", a), mMem[a], mem[a]);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* cpuCore.f */
+incdir+verification
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/datapath.sv
design/control.sv
design/cpuCore.sv
verification/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Builds the cpuCore testbench with Verilator, runs it and reports the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f cpuCore.f \
  --top-module cpuCoreTb -Mdir obj_dir -o cpuCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
